/* verilog/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Instruction memory word address width, 256 words
`define CPU_IMEM_AW 8

// Data memory word address width, 256 words
`define CPU_DMEM_AW 8

// General purpose registers, r0 hardwired to zero
`define CPU_NUM_REGS 16

`endif

/* verilog/cpu_pkg.sv */
package cpu_pkg;

	// Opcodes, instr[15:12]
	localparam logic [3:0] OP_ADD    = 4'd0;
	localparam logic [3:0] OP_SUB    = 4'd1;
	localparam logic [3:0] OP_XOR    = 4'd2;
	localparam logic [3:0] OP_RED    = 4'd3;
	localparam logic [3:0] OP_SLL    = 4'd4;
	localparam logic [3:0] OP_SRA    = 4'd5;
	localparam logic [3:0] OP_ROR    = 4'd6;
	localparam logic [3:0] OP_PADDSB = 4'd7;
	localparam logic [3:0] OP_LW     = 4'd8;
	localparam logic [3:0] OP_SW     = 4'd9;
	localparam logic [3:0] OP_LLB    = 4'd10;
	localparam logic [3:0] OP_LHB    = 4'd11;
	localparam logic [3:0] OP_B      = 4'd12;
	localparam logic [3:0] OP_BR     = 4'd13;
	localparam logic [3:0] OP_PCS    = 4'd14;
	localparam logic [3:0] OP_HLT    = 4'd15;

	// Branch condition codes, instr[11:9]
	localparam logic [2:0] CC_NE     = 3'b000;
	localparam logic [2:0] CC_EQ     = 3'b001;
	localparam logic [2:0] CC_GT     = 3'b010;
	localparam logic [2:0] CC_LT     = 3'b011;
	localparam logic [2:0] CC_GE     = 3'b100;
	localparam logic [2:0] CC_LE     = 3'b101;
	localparam logic [2:0] CC_OV     = 3'b110;
	localparam logic [2:0] CC_UNCOND = 3'b111;

	// Bit positions in the flag word
	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [3:0] rs;
			logic [3:0] rt;
		} r;
		struct packed {
			logic [3:0] opcode;
			logic [2:0] cond;
			logic [8:0] imm9;
		} b;
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [7:0] imm8;
		} lb;
	} instr_u;

endpackage

/* verilog/memory1c.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module memory1c #(
	parameter int AW = `CPU_IMEM_AW
) (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        wr,
	input  logic [15:0] addr,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	input  logic [15:0] addr2,
	output logic [15:0] rdata2
);

	logic [15:0] mem [2**AW];

	// Byte address in, word index is bits AW..1
	logic [AW-1:0] idx;
	logic [AW-1:0] idx2;

	assign idx  = addr[AW:1];
	assign idx2 = addr2[AW:1];

	// Clears to zero, i.e. ADD r0,r0,r0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**AW; i++) begin
				mem[i] <= 16'h0000;
			end
		end else if (wr) begin
			mem[idx] <= wdata;
		end
	end

	// Both reads combinational
	assign rdata  = mem[idx];
	assign rdata2 = mem[idx2];

endmodule

/* verilog/control_decode.sv */
`timescale 1ns/1ps

module control_decode (
	input  cpu_pkg::instr_u instr,
	output logic [3:0]      rs_idx,
	output logic [3:0]      rt_idx,
	output logic [3:0]      rd_idx,
	output logic            alu_b_imm,
	output logic [15:0]     imm4_sext,
	output logic            reg_write,
	output logic            mem_write,
	output logic            mem_to_reg,
	output logic            pc_to_reg,
	output logic            byte_load,
	output logic            byte_high,
	output logic            branch,
	output logic            branch_reg,
	output logic            halt
);
	import cpu_pkg::*;

	logic [3:0]  op;
	logic        rd_as_src;
	logic        mem_op;
	logic [15:0] imm_ext;

	assign op = instr.r.opcode;

	// Register fields
	assign rs_idx = instr.r.rs;
	assign rd_idx = instr.r.rd;

	// SW stores rd, LLB/LHB merge into rd, so rd goes out on the rt port
	assign rd_as_src = (op == OP_SW) || (op == OP_LLB) || (op == OP_LHB);
	assign rt_idx    = rd_as_src ? instr.r.rd : instr.r.rt;

	// LW and SW
	assign mem_op = (op == OP_LW) || (op == OP_SW);

	// Shifts (0100..0110) and all of 1xxx take the immediate
	assign alu_b_imm = op[3] | (op[2] & ~(op[1] & op[0]));

	// Shift amount as is, memory offset in halfwords
	assign imm_ext   = {{12{instr.r.rt[3]}}, instr.r.rt};
	assign imm4_sext = mem_op ? {imm_ext[14:0], 1'b0} : imm_ext;

	// ALU ops, LW, LLB, LHB, PCS write back
	assign reg_write = ~op[3] |
	                   (op[3] & ((~op[2] & ~op[1] & ~op[0]) |
	                             (~op[2] &  op[1]) |
	                             ( op[2] &  op[1] & ~op[0])));

	assign mem_write  = op[3] & ~op[2] & ~op[1] &  op[0];
	assign mem_to_reg = op[3] & ~op[2] & ~op[1] & ~op[0];
	assign pc_to_reg  = op[3] &  op[2] &  op[1] & ~op[0];

	// Load byte, opcode bit 0 picks the high byte
	assign byte_load = op[3] & ~op[2] & op[1];
	assign byte_high = op[0];

	// B and BR, bit 0 marks the register form
	assign branch     = op[3] & op[2] & ~op[1];
	assign branch_reg = branch & op[0];

	assign halt = &op;

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module register_file (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [3:0]  rs_idx,
	input  logic [3:0]  rt_idx,
	input  logic [3:0]  rd_idx,
	input  logic        write_en,
	input  logic [15:0] write_data,
	output logic [15:0] rs_data,
	output logic [15:0] rt_data
);

	logic [15:0] regs [`CPU_NUM_REGS];

	// Write at the edge, r0 never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= 16'h0000;
			end
		end else if (write_en && rd_idx != 4'd0) begin
			regs[rd_idx] <= write_data;
		end
	end

	// Combinational reads
	// Same-cycle write lands at the edge, the instruction reading it
	// is the one producing it
	assign rs_data = (rs_idx == 4'd0) ? 16'h0000 : regs[rs_idx];
	assign rt_data = (rt_idx == 4'd0) ? 16'h0000 : regs[rt_idx];

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
	input  logic [3:0]  op,
	input  logic [15:0] a,
	input  logic [15:0] b,
	output logic [15:0] result,
	output logic [2:0]  flags_next,
	output logic [2:0]  flag_mask
);
	import cpu_pkg::*;

	logic        is_sub;
	logic [15:0] addsub_b;
	logic [15:0] addsub_raw;
	logic [15:0] addsub_sat;
	logic        ovf;
	logic [3:0]  shamt;
	logic [9:0]  red_sum;
	logic [15:0] paddsb;

	// Signed 4-bit add, clamps to 7 or -8
	function automatic logic [3:0] sat_add4(input logic [3:0] x, input logic [3:0] y);
		logic [3:0] s;
		s = x + y;
		if (x[3] == y[3] && s[3] != x[3])
			return x[3] ? 4'h8 : 4'h7;
		return s;
	endfunction

	// Shared adder, SUB as a + ~b + 1
	assign is_sub     = (op == OP_SUB);
	assign addsub_b   = is_sub ? ~b : b;
	assign addsub_raw = a + addsub_b + {15'd0, is_sub};

	// Overflow when both inputs agree in sign and the sum does not
	assign ovf        = (a[15] == addsub_b[15]) && (addsub_raw[15] != a[15]);
	assign addsub_sat = ovf ? (a[15] ? 16'h8000 : 16'h7fff) : addsub_raw;

	assign shamt = b[3:0];

	// Four signed bytes summed, 10 bits hold the range
	assign red_sum = {{2{a[15]}}, a[15:8]} + {{2{a[7]}}, a[7:0]} +
	                 {{2{b[15]}}, b[15:8]} + {{2{b[7]}}, b[7:0]};

	// Nibble lanes
	assign paddsb = {sat_add4(a[15:12], b[15:12]), sat_add4(a[11:8], b[11:8]),
	                 sat_add4(a[7:4], b[7:4]), sat_add4(a[3:0], b[3:0])};

	always_comb begin
		case (op)
			OP_ADD, OP_SUB: result = addsub_sat;
			OP_XOR:         result = a ^ b;
			OP_RED:         result = {{6{red_sum[9]}}, red_sum};
			OP_SLL:         result = a << shamt;
			OP_SRA:         result = $signed(a) >>> shamt;
			// Zero amount leaves a, the left term shifts out entirely
			OP_ROR:         result = (a >> shamt) | (a << (5'd16 - {1'b0, shamt}));
			OP_PADDSB:      result = paddsb;
			// Base with bit 0 cleared plus halfword offset
			OP_LW, OP_SW:   result = {a[15:1], 1'b0} + b;
			default:        result = a;
		endcase
	end

	// Next flag values
	always_comb begin
		flags_next         = 3'b000;
		flags_next[FLAG_Z] = (result == 16'h0000);
		flags_next[FLAG_V] = ovf;
		flags_next[FLAG_N] = result[15];
	end

	// Which flags this op updates
	always_comb begin
		flag_mask = 3'b000;
		case (op)
			OP_ADD, OP_SUB: flag_mask = 3'b111;
			OP_XOR, OP_SLL, OP_SRA, OP_ROR: flag_mask[FLAG_Z] = 1'b1;
			default:        flag_mask = 3'b000;
		endcase
	end

endmodule

/* verilog/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            run,
	input  cpu_pkg::instr_u instr,
	input  logic            branch,
	input  logic            branch_reg,
	input  logic            halt,
	input  logic [15:0]     rs_data,
	input  logic [2:0]      flags_next,
	input  logic [2:0]      flag_mask,
	output logic [15:0]     pc,
	output logic [15:0]     pc_plus2
);
	import cpu_pkg::*;

	logic [2:0]  flags;
	logic        commit;
	logic        cond_true;
	logic [15:0] br_offset;
	logic [15:0] pc_next;

	assign commit   = run & ~halt;
	assign pc_plus2 = pc + 16'd2;

	// imm9 counts halfwords
	assign br_offset = {{6{instr.b.imm9[8]}}, instr.b.imm9, 1'b0};

	// Condition against flags left by earlier instructions
	always_comb begin
		case (instr.b.cond)
			CC_NE:     cond_true = ~flags[FLAG_Z];
			CC_EQ:     cond_true = flags[FLAG_Z];
			CC_GT:     cond_true = ~flags[FLAG_Z] & ~flags[FLAG_N];
			CC_LT:     cond_true = flags[FLAG_N];
			CC_GE:     cond_true = flags[FLAG_Z] | ~flags[FLAG_N];
			CC_LE:     cond_true = flags[FLAG_Z] | flags[FLAG_N];
			CC_OV:     cond_true = flags[FLAG_V];
			CC_UNCOND: cond_true = 1'b1;
			default:   cond_true = 1'b0;
		endcase
	end

	// Register target forced to a halfword boundary
	always_comb begin
		pc_next = pc_plus2;
		if (branch && cond_true)
			pc_next = branch_reg ? {rs_data[15:1], 1'b0} : pc_plus2 + br_offset;
	end

	// PC and flags move together on a committing instruction
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc    <= 16'h0000;
			flags <= 3'b000;
		end else if (commit) begin
			pc    <= pc_next;
			flags <= (flags & ~flag_mask) | (flags_next & flag_mask);
		end
	end

endmodule

/* verilog/cpu.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        run,
	input  logic        prog_wr,
	input  logic [15:0] prog_addr,
	input  logic [15:0] prog_data,
	input  logic [15:0] result_addr,
	output logic [15:0] result_data,
	output logic        hlt,
	output logic [15:0] pc
);
	import cpu_pkg::*;

	// Fetched instruction
	instr_u      instr;

	// Decode outputs
	logic [3:0]  rs_idx, rt_idx, rd_idx;
	logic        alu_b_imm;
	logic [15:0] imm4_sext;
	logic        reg_write, mem_write, mem_to_reg, pc_to_reg;
	logic        byte_load, byte_high;
	logic        branch, branch_reg, halt;

	// Datapath
	logic [15:0] rs_data, rt_data, wb_data;
	logic [15:0] alu_b, alu_result, dmem_rdata;
	logic [15:0] byte_merge, pc_plus2;
	logic [2:0]  flags_next, flag_mask;
	logic        commit;

	// Nothing commits while stopped or halted
	assign commit = run & ~halt;
	assign hlt    = halt;

	// Program is loaded through port 1, PC fetches on port 2
	memory1c #(.AW(`CPU_IMEM_AW)) u_imem (
		.clk(clk), .arst_n(arst_n), .wr(prog_wr), .addr(prog_addr), .wdata(prog_data),
		.rdata(), .addr2(pc), .rdata2(instr)
	);

	control_decode u_decode (
		.instr(instr), .rs_idx(rs_idx), .rt_idx(rt_idx), .rd_idx(rd_idx),
		.alu_b_imm(alu_b_imm), .imm4_sext(imm4_sext), .reg_write(reg_write),
		.mem_write(mem_write), .mem_to_reg(mem_to_reg), .pc_to_reg(pc_to_reg),
		.byte_load(byte_load), .byte_high(byte_high), .branch(branch),
		.branch_reg(branch_reg), .halt(halt)
	);

	register_file u_regs (
		.clk(clk), .arst_n(arst_n), .rs_idx(rs_idx), .rt_idx(rt_idx), .rd_idx(rd_idx),
		.write_en(reg_write & commit), .write_data(wb_data),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	// Immediate for shift amount and memory offset
	assign alu_b = alu_b_imm ? imm4_sext : rt_data;

	alu u_alu (
		.op(instr.r.opcode), .a(rs_data), .b(alu_b), .result(alu_result),
		.flags_next(flags_next), .flag_mask(flag_mask)
	);

	pc_unit u_pc (
		.clk(clk), .arst_n(arst_n), .run(run), .instr(instr), .branch(branch),
		.branch_reg(branch_reg), .halt(halt), .rs_data(rs_data),
		.flags_next(flags_next), .flag_mask(flag_mask), .pc(pc), .pc_plus2(pc_plus2)
	);

	// ALU result is the byte address, rt port carries the store data
	memory1c #(.AW(`CPU_DMEM_AW)) u_dmem (
		.clk(clk), .arst_n(arst_n), .wr(mem_write & commit), .addr(alu_result),
		.wdata(rt_data), .rdata(dmem_rdata), .addr2(result_addr), .rdata2(result_data)
	);

	// LLB/LHB keep the other byte of rd, read on the rt port
	assign byte_merge = byte_high ? {instr.lb.imm8, rt_data[7:0]}
	                              : {rt_data[15:8], instr.lb.imm8};

	// Write-back select
	assign wb_data = mem_to_reg ? dmem_rdata :
	                 pc_to_reg  ? pc_plus2   :
	                 byte_load  ? byte_merge : alu_result;

endmodule

/* testbench/cpu_asserts.sv */
`timescale 1ns/1ps

module cpu_asserts (
	input logic        clk,
	input logic        arst_n,
	input logic        hlt,
	input logic [15:0] pc
);

	// PC held at zero during reset
	pc_reset_zero: assert property (@(posedge clk) !arst_n |-> pc == 16'h0000)
		else $error("pc not zero while arst_n low");

	// Instructions sit on halfword boundaries
	pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[0] == 1'b0)
		else $error("pc is odd");

	// Halted CPU does not move
	pc_hold_on_hlt: assert property (@(posedge clk) disable iff (!arst_n)
		hlt |=> $stable(pc))
		else $error("pc moved while hlt high");

endmodule

// Attached to every cpu instance
bind cpu cpu_asserts u_asserts (
	.clk(clk),
	.arst_n(arst_n),
	.hlt(hlt),
	.pc(pc)
);

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu;
	import cpu_pkg::*;

	logic        clk;
	logic        arst_n;
	logic        run;
	logic        prog_wr;
	logic [15:0] prog_addr;
	logic [15:0] prog_data;
	logic [15:0] result_addr;
	logic [15:0] result_data;
	logic        hlt;
	logic [15:0] pc;

	int          errors;
	logic [15:0] lfsr;
	logic [15:0] prog[$];
	logic [15:0] exp_addr[$];
	logic [15:0] exp_val[$];

	cpu u_cpu (
		.clk(clk), .arst_n(arst_n), .run(run), .prog_wr(prog_wr), .prog_addr(prog_addr),
		.prog_data(prog_data), .result_addr(result_addr), .result_data(result_data),
		.hlt(hlt), .pc(pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Fibonacci LFSR with taps 16 14 13 11
	// Stepped once for every returned bit
	function automatic logic [15:0] rand_bits(input int n);
		logic        fb;
		logic [15:0] v;
		v = 16'h0000;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	// Instruction encoders
	function automatic logic [15:0] enc_r(input logic [3:0] op, input logic [3:0] rd,
	                                      input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] enc_b(input logic [2:0] cc, input logic [8:0] imm9);
		return {OP_B, cc, imm9};
	endfunction

	// Saturating add or subtract returning {V, result}
	function automatic logic [16:0] model_arith(input logic [15:0] a, input logic [15:0] b,
	                                            input logic sub);
		int s;
		s = sub ? int'($signed(a)) - int'($signed(b)) : int'($signed(a)) + int'($signed(b));
		if (s > 32767)
			return {1'b1, 16'h7fff};
		if (s < -32768)
			return {1'b1, 16'h8000};
		return {1'b0, s[15:0]};
	endfunction

	function automatic logic [15:0] model_red(input logic [15:0] a, input logic [15:0] b);
		int s;
		s = int'($signed(a[15:8])) + int'($signed(a[7:0])) +
		    int'($signed(b[15:8])) + int'($signed(b[7:0]));
		return s[15:0];
	endfunction

	function automatic logic [15:0] model_paddsb(input logic [15:0] a, input logic [15:0] b);
		logic [15:0] r;
		int s;
		for (int i = 0; i < 4; i++) begin
			s = int'($signed(a[i*4 +: 4])) + int'($signed(b[i*4 +: 4]));
			if (s > 7)
				s = 7;
			if (s < -8)
				s = -8;
			r[i*4 +: 4] = s[3:0];
		end
		return r;
	endfunction

	// One bit position per loop pass
	function automatic logic [15:0] model_shift(input logic [3:0] op, input logic [15:0] a,
	                                            input logic [3:0] n);
		logic [15:0] r;
		r = a;
		for (int i = 0; i < int'(n); i++) begin
			if (op == OP_SLL)
				r = {r[14:0], 1'b0};
			else if (op == OP_SRA)
				r = {r[15], r[15:1]};
			else
				r = {r[0], r[15:1]};
		end
		return r;
	endfunction

	function automatic logic cond_taken(input logic [2:0] cc, input logic z, input logic v,
	                                    input logic n);
		case (cc)
			3'd0: return !z;
			3'd1: return z;
			3'd2: return !z && !n;
			3'd3: return n;
			3'd4: return z || !n;
			3'd5: return z || n;
			3'd6: return v;
			default: return 1'b1;
		endcase
	endfunction

	// Program building
	task automatic emit(input logic [15:0] w);
		prog.push_back(w);
	endtask

	task automatic emit_const(input logic [3:0] rd, input logic [15:0] val);
		emit({OP_LLB, rd, val[7:0]});
		emit({OP_LHB, rd, val[15:8]});
	endtask

	// r14 holds the store address
	task automatic emit_store(input logic [3:0] rs, input logic [15:0] addr,
	                          input logic [15:0] expv);
		emit_const(4'd14, addr);
		emit(enc_r(OP_SW, rs, 4'd14, 4'd0));
		exp_addr.push_back(addr);
		exp_val.push_back(expv);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		arst_n    <= 1'b0;
		run       <= 1'b0;
		prog_wr   <= 1'b0;
		repeat (10) @(posedge clk);
		arst_n    <= 1'b1;
	endtask

	task automatic load_word(input logic [15:0] addr, input logic [15:0] data);
		@(posedge clk);
		prog_wr   <= 1'b1;
		prog_addr <= addr;
		prog_data <= data;
	endtask

	// Run stays high afterwards so the halted state can be observed
	task automatic run_until_halt();
		int cycles;
		@(posedge clk);
		run <= 1'b1;
		cycles = 0;
		while (cycles < 2000) begin
			@(negedge clk);
			if (hlt)
				break;
			cycles++;
		end
		if (cycles >= 2000) begin
			$display("Timeout: CPU did not halt within 2000 cycles");
			errors++;
		end
	endtask

	task automatic read_result(input logic [15:0] addr, output logic [15:0] data);
		@(posedge clk);
		result_addr <= addr;
		@(negedge clk);
		data = result_data;
	endtask

	// Fresh reset then load, run and compare every stored word
	task automatic run_program(input string name);
		logic [15:0] got;
		emit({OP_HLT, 12'h000});
		if (prog.size() > 2**`CPU_IMEM_AW) begin
			$display("Program %s does not fit in instruction memory", name);
			errors++;
		end
		apply_reset();
		foreach (prog[i])
			load_word(16'(i * 2), prog[i]);
		@(posedge clk);
		prog_wr <= 1'b0;
		run_until_halt();
		foreach (exp_addr[i]) begin
			read_result(exp_addr[i], got);
			if (got !== exp_val[i]) begin
				$display("FAIL %s result_data[%h] got %h expected %h", name, exp_addr[i],
				         got, exp_val[i]);
				errors++;
			end
		end
		prog.delete();
		exp_addr.delete();
		exp_val.delete();
	endtask

	task automatic test_arith();
		logic [15:0] a, b;
		logic [16:0] r;
		a = rand_bits(16);
		b = rand_bits(16);
		emit_const(4'd1, a);
		emit_const(4'd2, b);
		emit(enc_r(OP_ADD, 4'd3, 4'd1, 4'd2));
		r = model_arith(a, b, 1'b0);
		emit_store(4'd3, 16'h0000, r[15:0]);
		emit(enc_r(OP_SUB, 4'd3, 4'd1, 4'd2));
		r = model_arith(a, b, 1'b1);
		emit_store(4'd3, 16'h0002, r[15:0]);
		emit(enc_r(OP_XOR, 4'd3, 4'd1, 4'd2));
		emit_store(4'd3, 16'h0004, a ^ b);
		emit(enc_r(OP_RED, 4'd3, 4'd1, 4'd2));
		emit_store(4'd3, 16'h0006, model_red(a, b));
		emit(enc_r(OP_PADDSB, 4'd3, 4'd1, 4'd2));
		emit_store(4'd3, 16'h0008, model_paddsb(a, b));
		// Saturating corners
		emit_const(4'd1, 16'h7000);
		emit_const(4'd2, 16'h2000);
		emit(enc_r(OP_ADD, 4'd3, 4'd1, 4'd2));
		emit_store(4'd3, 16'h000a, 16'h7fff);
		emit_const(4'd1, 16'h8000);
		emit_const(4'd2, 16'h0001);
		emit(enc_r(OP_SUB, 4'd3, 4'd1, 4'd2));
		emit_store(4'd3, 16'h000c, 16'h8000);
		run_program("arith");
	endtask

	task automatic test_shifts();
		logic [15:0] a, amt;
		logic [3:0]  ops[3];
		ops = '{OP_SLL, OP_SRA, OP_ROR};
		a = rand_bits(16);
		emit_const(4'd1, a);
		for (int k = 0; k < 6; k++) begin
			amt = rand_bits(4);
			emit(enc_r(ops[k % 3], 4'd3, 4'd1, amt[3:0]));
			emit_store(4'd3, 16'(16'h0010 + k * 2), model_shift(ops[k % 3], a, amt[3:0]));
		end
		run_program("shifts");
	endtask

	task automatic test_memory();
		logic [15:0] v;
		v = rand_bits(16);
		emit_const(4'd1, v);
		emit_const(4'd5, 16'h0110);
		// Offset -2 halfwords lands on 0x010c
		emit(enc_r(OP_SW, 4'd1, 4'd5, 4'he));
		exp_addr.push_back(16'h010c);
		exp_val.push_back(v);
		emit(enc_r(OP_LW, 4'd6, 4'd5, 4'he));
		emit_store(4'd6, 16'h0020, v);
		emit(enc_r(OP_ADD, 4'd0, 4'd1, 4'd1));
		emit_store(4'd0, 16'h0022, 16'h0000);
		run_program("memory");
	endtask

	// Four flag scenarios of equal SUB, random SUB, overflowing ADD and negative SUB
	task automatic test_branches();
		logic [15:0] a, b;
		logic [16:0] r;
		logic        sub;
		for (int s = 0; s < 4; s++) begin
			for (int cc = 0; cc < 8; cc++) begin
				a = rand_bits(16);
				b = rand_bits(16);
				sub = 1'b1;
				if (s == 0)
					b = a;
				if (s == 2) begin
					a = 16'h7000;
					b = 16'h2000;
					sub = 1'b0;
				end
				if (s == 3) begin
					a = 16'h0001;
					b = 16'h0005;
				end
				r = model_arith(a, b, sub);
				emit_const(4'd1, a);
				emit_const(4'd2, b);
				emit(enc_r(sub ? OP_SUB : OP_ADD, 4'd3, 4'd1, 4'd2));
				emit(enc_b(3'(cc), 9'd3));
				// Untaken path then skip over taken path
				emit_const(4'd7, 16'(16'h00a0 + cc));
				emit(enc_b(CC_UNCOND, 9'd2));
				emit_const(4'd7, 16'(16'h00b0 + cc));
				emit_store(4'd7, 16'(16'h0040 + cc * 2),
				           cond_taken(3'(cc), r[15:0] == 16'h0000, r[16], r[15]) ?
				           16'(16'h00b0 + cc) : 16'(16'h00a0 + cc));
			end
			run_program("branches");
		end
	endtask

	task automatic test_br_pcs_halt();
		logic [15:0] halt_addr;
		emit(enc_r(OP_PCS, 4'd4, 4'd0, 4'd0));
		emit_store(4'd4, 16'h0060, 16'h0002);
		emit_const(4'd5, 16'd30);
		emit(enc_r(OP_ADD, 4'd4, 4'd4, 4'd5));
		// BR uncond to r4 = 32
		emit({OP_BR, CC_UNCOND, 1'b0, 4'd4, 4'd0});
		// Reached only if BR falls through
		emit({OP_HLT, 12'h000});
		while (prog.size() < 16)
			emit(16'h0000);
		emit_const(4'd7, 16'h600d);
		emit_store(4'd7, 16'h0062, 16'h600d);
		// Final HLT goes right after the last emitted word
		halt_addr = 16'(prog.size() * 2);
		run_program("br_pcs");
		@(negedge clk);
		if (pc !== halt_addr) begin
			$display("FAIL pc got %h expected %h", pc, halt_addr);
			errors++;
		end
		if (hlt !== 1'b1) begin
			$display("FAIL hlt got %h expected %h", hlt, 1'b1);
			errors++;
		end
		repeat (20) @(negedge clk);
		if (pc !== halt_addr) begin
			$display("FAIL pc after halt got %h expected %h", pc, halt_addr);
			errors++;
		end
	endtask

	initial begin
		errors      = 0;
		lfsr        = 16'd59;
		arst_n      = 1'b0;
		run         = 1'b0;
		prog_wr     = 1'b0;
		prog_addr   = 16'h0000;
		prog_data   = 16'h0000;
		result_addr = 16'h0000;
		test_arith();
		test_shifts();
		test_memory();
		test_branches();
		test_br_pcs_halt();
		$display("Checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/memory1c.sv
verilog/control_decode.sv
verilog/register_file.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/cpu.sv
testbench/cpu_asserts.sv
testbench/tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_cpu -f sources.f -o Vtb_cpu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_cpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Verification passed$"; then
	exit 0
fi
exit 1
